// ==== files.f ====
verilog/link_pkg.sv
verilog/meas_pkg.sv
verilog/frame_parser.sv
verilog/tag_converter.sv
verilog/count_rate_regs.sv
verilog/tag_link_top.sv
verif/tb_tag_link.sv

// ==== verif/tb_tag_link.sv ====
// Directed testbench for the time-tag frame receiver
// Expected output beats come from a model of the decoding rules and are checked in order
// Stimulus changes 1 unit after the rising edge and outputs are sampled on the falling edge
module tb_tag_link;
    import link_pkg::*;
    import meas_pkg::*;

    localparam logic [31:0] SEED      = 32'h00b9_16b0;
    localparam int          TIMEOUT   = 2000;
    localparam tag_word_u   FILL_WORD = '0;

    logic                  sys_clk = 1'b0;
    logic                  sys_clk_rst;
    logic                  s_valid_i;
    beat_u                 s_data_i;
    lane_mask_t            s_keep_i;
    logic                  s_last_i;
    logic                  s_ready_o;
    logic                  m_valid_o;
    lane_mask_t            m_lane_valid_o;
    time_vec_t             m_time_o;
    chan_vec_t             m_channel_o;
    logic                  m_ready_i;
    logic                  rd_en_i;
    logic [REG_ADDR_W-1:0] rd_addr_i;
    logic [31:0]           rd_data_o;
    logic                  rd_valid_o;

    // Separate LCG streams for tag stimulus and for output back-pressure
    logic [31:0] stim_rng  = SEED;
    logic [31:0] ready_rng = SEED;
    logic        rand_ready = 1'b0;

    // Reference model state
    logic [63:0] model_wrap;
    int          model_count [1:COUNT_CHANNELS];
    int          model_ok;
    int          model_drop;
    int          seq_num;
    beat_u       pay_q [$];
    lane_mask_t  keep_q [$];
    lane_mask_t  exp_mask [$];
    time_vec_t   exp_time [$];
    chan_vec_t   exp_chan [$];
    int          err_count;
    int          check_count;
    int          tests_run;
    int          tests_bad;
    int          err_mark;

    tag_link_top dut (.*);

    always #2 sys_clk = ~sys_clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = lcg_step(stim_rng);
        return stim_rng;
    endfunction

    function automatic tag_word_u tag_word(input chan_t ch, input logic [23:0] sub);
        tag_word_u w;
        w.evt.kind    = KIND_TAG;
        w.evt.channel = ch;
        w.evt.subtime = sub;
        return w;
    endfunction

    function automatic tag_word_u wrap_word(input logic [29:0] inc);
        tag_word_u w;
        w.wrap.kind     = KIND_WRAP;
        w.wrap.wrap_inc = inc;
        return w;
    endfunction

    task automatic check_time(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s time %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_channel(input chan_t got, input chan_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s channel %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(input lane_mask_t got, input lane_mask_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s mask %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED at %0t: %s reads %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("TEST FAILED");
        $finish;
    endtask

    // Holds the beat until the DUT takes it and returns 1 unit after the transfer edge
    task automatic push_beat(input beat_u data, input lane_mask_t keep, input logic last);
        int n;
        s_valid_i = 1'b1;
        s_data_i  = data;
        s_keep_i  = keep;
        s_last_i  = last;
        n = 0;
        @(negedge sys_clk);
        while (!s_ready_o) begin
            n++;
            if (n > TIMEOUT) report_timeout("input handshake");
            @(negedge sys_clk);
        end
        @(posedge sys_clk);
        #1;
        s_valid_i = 1'b0;
        s_last_i  = 1'b0;
    endtask

    task automatic add_beat(input tag_word_u w0, input tag_word_u w1, input tag_word_u w2,
                            input tag_word_u w3, input lane_mask_t keep);
        beat_u b;
        b.lane[0] = w0;
        b.lane[1] = w1;
        b.lane[2] = w2;
        b.lane[3] = w3;
        pay_q.push_back(b);
        keep_q.push_back(keep);
    endtask

    // Timestamp is wrap count times 2^24 plus subtime with lanes walked from 0 upward
    task automatic model_beat(input beat_u b, input lane_mask_t keep);
        lane_mask_t m;
        time_vec_t  t;
        chan_vec_t  c;
        m = '0;
        t = '0;
        c = '0;
        for (int i = 0; i < LANES; i++) begin
            if (keep[i] && b.lane[i].wrap.kind == KIND_WRAP) begin
                model_wrap = model_wrap + 64'(b.lane[i].wrap.wrap_inc);
            end else if (keep[i] && b.lane[i].evt.kind == KIND_TAG) begin
                m[i] = 1'b1;
                t[i] = (model_wrap << SUBTIME_W) + 64'(b.lane[i].evt.subtime);
                c[i] = b.lane[i].evt.channel;
                if (c[i] >= 1 && c[i] <= COUNT_CHANNELS) model_count[int'(c[i])]++;
            end
        end
        if (m != '0) begin
            exp_mask.push_back(m);
            exp_time.push_back(t);
            exp_chan.push_back(c);
        end
    endtask

    // Sends a header and the queued payload beats as one frame
    task automatic send_frame(input logic [15:0] magic, input logic [31:0] base);
        beat_u hdr;
        int    n;
        n = pay_q.size();
        hdr = '0;
        hdr.hdr.magic     = magic;
        hdr.hdr.seq_num   = seq_num;
        hdr.hdr.wrap_base = base;
        seq_num++;
        if (magic == FRAME_MAGIC) model_ok++;
        else model_drop++;
        model_wrap = 64'(base);
        push_beat(hdr, '0, n == 0);
        for (int i = 0; i < n; i++) begin
            if (magic == FRAME_MAGIC) model_beat(pay_q[i], keep_q[i]);
            push_beat(pay_q[i], keep_q[i], i == n - 1);
        end
        pay_q.delete();
        keep_q.delete();
    endtask

    task automatic check_read(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] exp,
                              input string what);
        int n;
        rd_en_i   = 1'b1;
        rd_addr_i = addr;
        @(posedge sys_clk);
        #1;
        rd_en_i = 1'b0;
        n = 0;
        @(negedge sys_clk);
        while (!rd_valid_o) begin
            n++;
            if (n > TIMEOUT) report_timeout("register read");
            @(negedge sys_clk);
        end
        // Read data is due one cycle after rd_en_i
        if (n != 0) begin
            err_count++;
            $display("Register read of %s at time %0t came %0d cycles late", what, $time, n);
        end
        check_reg(rd_data_o, exp, what);
        @(posedge sys_clk);
        #1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_mask.size() != 0) begin
            n++;
            if (n > TIMEOUT) report_timeout("expected output beats");
            @(posedge sys_clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count != err_mark) tests_bad++;
        $display("test %0d %s: %0d errors", tests_run, name, err_count - err_mark);
        err_mark = err_count;
    endtask

    // A beat seen by the output collector transfers on the next rising edge
    always @(negedge sys_clk) begin : collect
        if (!sys_clk_rst && m_valid_o && m_ready_i) begin
            if (exp_mask.size() == 0) begin
                err_count++;
                $display("Output beat at time %0t arrived while none was expected", $time);
            end else begin
                check_mask(m_lane_valid_o, exp_mask[0], "output");
                for (int i = 0; i < LANES; i++) begin
                    if (exp_mask[0][i]) begin
                        check_time(m_time_o[i], exp_time[0][i], "lane");
                        check_channel(m_channel_o[i], exp_chan[0][i], "lane");
                    end
                end
                void'(exp_mask.pop_front());
                void'(exp_time.pop_front());
                void'(exp_chan.pop_front());
            end
        end
    end

    // Random back-pressure while rand_ready is set
    always @(posedge sys_clk) begin
        #1;
        if (rand_ready) begin
            ready_rng = lcg_step(ready_rng);
            m_ready_i = ready_rng[16];
        end
    end

    task automatic test_reset_values();
        check_read(ADDR_ID, DESIGN_ID, "design id");
        check_read(ADDR_FRAMES_OK, 32'd0, "frames ok");
        check_read(ADDR_FRAMES_DROPPED, 32'd0, "frames dropped");
        for (int c = 1; c <= COUNT_CHANNELS; c++) begin
            check_read(REG_ADDR_W'(ADDR_COUNT_BASE + c - 1), 32'd0, "channel count");
        end
        finish_test("reset values");
    endtask

    task automatic test_plain_tags();
        add_beat(tag_word(6'sd1, 24'h000010), tag_word(-6'sd3, 24'hffffff),
                 tag_word(6'sd8, 24'h123456), tag_word(6'sd2, 24'h000000), 4'b1111);
        // Lanes 0 and 2 lose keep and must come out invalid
        add_beat(tag_word(6'sd4, 24'h00abcd), tag_word(6'sd5, 24'h000001),
                 tag_word(-6'sd1, 24'h000002), tag_word(6'sd7, 24'h000003), 4'b1010);
        send_frame(FRAME_MAGIC, 32'h0000_1234);
        wait_drain();
        finish_test("plain tags");
    endtask

    task automatic test_wrap_markers();
        add_beat(tag_word(6'sd1, 24'h000100), wrap_word(30'd5),
                 tag_word(6'sd2, 24'h000200), wrap_word(30'd1), 4'b1111);
        // Wrap in lane 1 has no keep and is ignored
        add_beat(tag_word(6'sd3, 24'h000300), wrap_word(30'd100),
                 wrap_word(30'd2), tag_word(6'sd4, 24'h000400), 4'b1101);
        send_frame(FRAME_MAGIC, 32'h0000_0010);
        add_beat(tag_word(6'sd5, 24'h000500), wrap_word(30'd3),
                 tag_word(6'sd6, 24'h000600), FILL_WORD, 4'b0111);
        send_frame(FRAME_MAGIC, 32'h0000_0020);
        wait_drain();
        finish_test("wrap markers");
    endtask

    task automatic test_bad_magic();
        add_beat(tag_word(6'sd1, 24'h000001), tag_word(6'sd2, 24'h000002),
                 FILL_WORD, FILL_WORD, 4'b1111);
        add_beat(tag_word(6'sd3, 24'h000003), FILL_WORD, FILL_WORD, FILL_WORD, 4'b1111);
        send_frame(16'h1234, 32'h0000_0099);
        // Header-only bad frame
        send_frame(16'h0000, 32'h0000_0000);
        add_beat(tag_word(6'sd8, 24'h000008), FILL_WORD, FILL_WORD, FILL_WORD, 4'b0001);
        send_frame(FRAME_MAGIC, 32'h0000_0077);
        wait_drain();
        check_read(ADDR_FRAMES_OK, 32'(model_ok), "frames ok");
        check_read(ADDR_FRAMES_DROPPED, 32'(model_drop), "frames dropped");
        finish_test("bad magic");
    endtask

    task automatic test_random_traffic();
        tag_word_u w [LANES];
        rand_ready = 1'b1;
        for (int f = 0; f < 8; f++) begin
            for (int b = 0; b < 4; b++) begin
                for (int i = 0; i < LANES; i++) begin
                    w[i] = tag_word_u'(next_rand());
                    // Channels -4 to 11 cover falling, counted and uncounted values
                    w[i].evt.channel = chan_t'(w[i].evt.channel[3:0]) - 6'sd4;
                end
                add_beat(w[0], w[1], w[2], w[3], lane_mask_t'(next_rand() >> 20));
            end
            send_frame(FRAME_MAGIC, next_rand());
        end
        rand_ready = 1'b0;
        m_ready_i  = 1'b1;
        wait_drain();
        finish_test("random traffic");
    endtask

    task automatic test_channel_counts();
        for (int c = 1; c <= COUNT_CHANNELS; c++) begin
            check_read(REG_ADDR_W'(ADDR_COUNT_BASE + c - 1), 32'(model_count[c]),
                       "channel count");
        end
        check_read(REG_ADDR_W'(ADDR_COUNT_BASE + COUNT_CHANNELS), 32'd0, "unmapped address");
        finish_test("channel counts");
    endtask

    initial begin
        sys_clk_rst = 1'b1;
        s_valid_i   = 1'b0;
        s_data_i    = '0;
        s_keep_i    = '0;
        s_last_i    = 1'b0;
        m_ready_i   = 1'b1;
        rd_en_i     = 1'b0;
        rd_addr_i   = '0;
        for (int c = 1; c <= COUNT_CHANNELS; c++) model_count[c] = 0;
        repeat (4) @(posedge sys_clk);
        #1;
        sys_clk_rst = 1'b0;
        test_reset_values();
        test_plain_tags();
        test_wrap_markers();
        test_bad_magic();
        test_random_traffic();
        test_channel_counts();
        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/count_rate_regs.sv ====
// Per-channel rising edge counters with a small read-only register port
// Only channels 1 to 8 are counted; falling edges and others are ignored
// All counters wrap at 2^COUNT_W; read data arrives one cycle after rd_en_i
module count_rate_regs (
    input  logic                            sys_clk,
    input  logic                            sys_clk_rst,
    input  logic                            m_valid_i,
    input  logic                            m_ready_i,
    input  link_pkg::lane_mask_t            m_lane_valid_i,
    input  link_pkg::chan_vec_t             m_channel_i,
    input  logic                            frame_ok_i,
    input  logic                            frame_drop_i,
    input  logic                            rd_en_i,
    input  logic [meas_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic [31:0]                     rd_data_o,
    output logic                            rd_valid_o
);
    import link_pkg::*;
    import meas_pkg::*;

    logic [COUNT_W-1:0] count_q [COUNT_CHANNELS];
    logic [COUNT_W-1:0] frames_ok_q;
    logic [COUNT_W-1:0] frames_drop_q;

    // Up to four hits per channel in one beat
    logic [2:0]            inc [COUNT_CHANNELS];
    logic                  xfer;
    logic [REG_ADDR_W-1:0] cnt_idx;
    logic [31:0]           rd_mux;
    logic [31:0]           rd_data_q;
    logic                  rd_valid_q;

    assign xfer = m_valid_i && m_ready_i;

    // Hits per channel in the current beat
    always_comb begin
        for (int c = 0; c < COUNT_CHANNELS; c++) begin
            inc[c] = '0;
            for (int l = 0; l < LANES; l++) begin
                if (m_lane_valid_i[l] && m_channel_i[l] == c + 1) begin
                    inc[c] = inc[c] + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            for (int c = 0; c < COUNT_CHANNELS; c++) begin
                count_q[c] <= '0;
            end
            frames_ok_q   <= '0;
            frames_drop_q <= '0;
        end else begin
            if (xfer) begin
                for (int c = 0; c < COUNT_CHANNELS; c++) begin
                    count_q[c] <= count_q[c] + COUNT_W'(inc[c]);
                end
            end
            frames_ok_q   <= frames_ok_q + COUNT_W'(frame_ok_i);
            frames_drop_q <= frames_drop_q + COUNT_W'(frame_drop_i);
        end
    end

    // Address decode
    assign cnt_idx = rd_addr_i - ADDR_COUNT_BASE;

    always_comb begin
        rd_mux = '0;
        if (rd_addr_i == ADDR_ID) begin
            rd_mux = DESIGN_ID;
        end else if (rd_addr_i == ADDR_FRAMES_OK) begin
            rd_mux = frames_ok_q;
        end else if (rd_addr_i == ADDR_FRAMES_DROPPED) begin
            rd_mux = frames_drop_q;
        end else if (rd_addr_i >= ADDR_COUNT_BASE &&
                     cnt_idx < REG_ADDR_W'(COUNT_CHANNELS)) begin
            rd_mux = count_q[cnt_idx[$clog2(COUNT_CHANNELS)-1:0]];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en_i;
        end
    end

    // Read data holds between reads
    always_ff @(posedge sys_clk) begin
        if (rd_en_i) begin
            rd_data_q <= rd_mux;
        end
    end

    assign rd_data_o  = rd_data_q;
    assign rd_valid_o = rd_valid_q;

endmodule

// ==== verilog/frame_parser.sv ====
// Frame header check and payload forwarding
// The first beat of each frame is taken as a header; s_keep_i is ignored there
// Bad frames are consumed up to s_last_i and never reach the output
// One output register, so s_ready_o follows pay_ready_i when it is full
module frame_parser (
    input  logic                 sys_clk,
    input  logic                 sys_clk_rst,
    input  logic                 s_valid_i,
    input  link_pkg::beat_u      s_data_i,
    input  link_pkg::lane_mask_t s_keep_i,
    input  logic                 s_last_i,
    output logic                 s_ready_o,
    output logic                 pay_valid_o,
    output link_pkg::beat_u      pay_lanes_o,
    output link_pkg::lane_mask_t pay_keep_o,
    output logic                 pay_first_o,
    output logic [31:0]          pay_wrap_base_o,
    input  logic                 pay_ready_i,
    output logic                 frame_ok_o,
    output logic                 frame_drop_o
);
    import link_pkg::*;

    logic [1:0]  state_q;
    logic        first_pend_q;
    logic        out_valid_q;
    beat_u       out_lanes_q;
    lane_mask_t  out_keep_q;
    logic        out_first_q;
    logic [31:0] wrap_base_q;
    logic        frame_ok_q;
    logic        frame_drop_q;

    logic accept;
    logic magic_ok;

    // Free when empty or drained on this edge
    assign s_ready_o = !out_valid_q || pay_ready_i;
    assign accept    = s_valid_i && s_ready_o;
    assign magic_ok  = (s_data_i.hdr.magic == FRAME_MAGIC);

    // State machine and output valid
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            state_q      <= PARSE_HEADER;
            first_pend_q <= 1'b0;
            out_valid_q  <= 1'b0;
            frame_ok_q   <= 1'b0;
            frame_drop_q <= 1'b0;
        end else begin
            frame_ok_q   <= 1'b0;
            frame_drop_q <= 1'b0;
            // Drained beat leaves the register empty unless refilled below
            if (pay_ready_i) begin
                out_valid_q <= 1'b0;
            end
            if (accept) begin
                case (state_q)
                    PARSE_HEADER: begin
                        frame_ok_q   <= magic_ok;
                        frame_drop_q <= !magic_ok;
                        first_pend_q <= magic_ok;
                        // Single-beat frame stays in header
                        if (!s_last_i) begin
                            state_q <= magic_ok ? PARSE_PAYLOAD : PARSE_DROP;
                        end
                    end
                    PARSE_PAYLOAD: begin
                        out_valid_q  <= 1'b1;
                        first_pend_q <= 1'b0;
                        if (s_last_i) begin
                            state_q <= PARSE_HEADER;
                        end
                    end
                    default: begin
                        // Drop: swallow beats until the frame ends
                        if (s_last_i) begin
                            state_q <= PARSE_HEADER;
                        end
                    end
                endcase
            end
        end
    end

    // Payload register and header latch
    always_ff @(posedge sys_clk) begin
        if (accept && state_q == PARSE_PAYLOAD) begin
            out_lanes_q <= s_data_i;
            out_keep_q  <= s_keep_i;
            out_first_q <= first_pend_q;
        end
        // Header only lands once the previous payload beat has left
        if (accept && state_q == PARSE_HEADER && magic_ok) begin
            wrap_base_q <= s_data_i.hdr.wrap_base;
        end
    end

    assign pay_valid_o     = out_valid_q;
    assign pay_lanes_o     = out_lanes_q;
    assign pay_keep_o      = out_keep_q;
    assign pay_first_o     = out_first_q;
    assign pay_wrap_base_o = wrap_base_q;
    assign frame_ok_o      = frame_ok_q;
    assign frame_drop_o    = frame_drop_q;

endmodule

// ==== verilog/link_pkg.sv ====
// Link protocol definitions shared by the parser and the tag converter
// Beats are 128 bits with four 32-bit tag lanes, lane 0 in the low bits
// Timestamps are 64 bits and wrap at 2^64; the wrap count keeps 40 bits
package link_pkg;

    // Beat geometry
    localparam int LANES     = 4;
    localparam int TAG_W     = 32;
    localparam int BEAT_W    = 128;
    localparam int SUBTIME_W = 24;
    localparam int TIME_W    = 64;

    // Value every valid header must carry
    localparam logic [15:0] FRAME_MAGIC = 16'h5449;

    // Tag kinds, kind 3 is handled as fill
    localparam logic [1:0] KIND_FILL = 2'd0;
    localparam logic [1:0] KIND_TAG  = 2'd1;
    localparam logic [1:0] KIND_WRAP = 2'd2;

    // Frame parser states
    localparam logic [1:0] PARSE_HEADER  = 2'd0;
    localparam logic [1:0] PARSE_PAYLOAD = 2'd1;
    localparam logic [1:0] PARSE_DROP    = 2'd2;

    // Signed channel, negative values are falling edges
    typedef logic signed [5:0] chan_t;

    // Event view of a tag word
    typedef struct packed {
        logic [1:0]           kind;
        chan_t                channel;
        logic [SUBTIME_W-1:0] subtime;
    } tag_event_t;

    // Wrap marker view of a tag word
    typedef struct packed {
        logic [1:0]       kind;
        logic [TAG_W-3:0] wrap_inc;
    } tag_wrap_t;

    typedef union packed {
        tag_event_t evt;
        tag_wrap_t  wrap;
    } tag_word_u;

    // Header view, magic in the top bits
    typedef struct packed {
        logic [15:0]        magic;
        logic [BEAT_W-81:0] reserved;
        logic [31:0]        seq_num;
        logic [31:0]        wrap_base;
    } frame_hdr_t;

    typedef union packed {
        frame_hdr_t             hdr;
        tag_word_u [LANES-1:0]  lane;
    } beat_u;

    typedef logic [LANES-1:0] lane_mask_t;
    typedef logic [LANES-1:0][TIME_W-1:0] time_vec_t;
    typedef chan_t [LANES-1:0] chan_vec_t;

endpackage

// ==== verilog/meas_pkg.sv ====
// Measurement constants and the read-only register map
// Counters cover rising edges on channels 1 to 8 only
// Unmapped addresses read back as zero
package meas_pkg;

    // Count-rate block sizing
    localparam int COUNT_CHANNELS = 8;
    localparam int COUNT_W        = 32;

    // Identifier returned at address 0
    localparam logic [31:0] DESIGN_ID = 32'h0000_0001;

    // Register port address width
    localparam int REG_ADDR_W = 8;

    // Address map
    localparam logic [REG_ADDR_W-1:0] ADDR_ID             = 8'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_FRAMES_OK      = 8'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_FRAMES_DROPPED = 8'd2;

    // Channel c reads at ADDR_COUNT_BASE + c - 1
    localparam logic [REG_ADDR_W-1:0] ADDR_COUNT_BASE     = 8'd8;

endpackage

// ==== verilog/tag_converter.sv ====
// Tag lane decoder and 64-bit timestamp builder
// Wrap count reloads from the header wrap base on the first payload beat
// Lanes are walked 0 to 3, so a wrap marker moves later lanes of its own beat
// Beats without any time tag still update the wrap count but emit nothing
module tag_converter (
    input  logic                 sys_clk,
    input  logic                 sys_clk_rst,
    input  logic                 pay_valid_i,
    input  link_pkg::beat_u      pay_lanes_i,
    input  link_pkg::lane_mask_t pay_keep_i,
    input  logic                 pay_first_i,
    input  logic [31:0]          pay_wrap_base_i,
    output logic                 pay_ready_o,
    output logic                 m_valid_o,
    output link_pkg::lane_mask_t m_lane_valid_o,
    output link_pkg::time_vec_t  m_time_o,
    output link_pkg::chan_vec_t  m_channel_o,
    input  logic                 m_ready_i
);
    import link_pkg::*;

    // Upper timestamp bits above the subtime field
    logic [TIME_W-SUBTIME_W-1:0] wrap_cnt_q;
    logic [TIME_W-SUBTIME_W-1:0] wrap_next;

    lane_mask_t lane_valid_next;
    time_vec_t  time_next;
    chan_vec_t  chan_next;
    logic       accept;
    logic       has_tag;

    logic       m_valid_q;
    lane_mask_t m_lane_valid_q;
    time_vec_t  m_time_q;
    chan_vec_t  m_channel_q;

    assign pay_ready_o = !m_valid_q || m_ready_i;
    assign accept      = pay_valid_i && pay_ready_o;
    assign has_tag     = |lane_valid_next;

    // Walk the lanes in order with a running wrap count
    always_comb begin
        wrap_next = pay_first_i ? (TIME_W - SUBTIME_W)'(pay_wrap_base_i) : wrap_cnt_q;
        for (int i = 0; i < LANES; i++) begin
            lane_valid_next[i] = 1'b0;
            time_next[i]       = '0;
            chan_next[i]       = pay_lanes_i.lane[i].evt.channel;
            if (pay_keep_i[i]) begin
                case (pay_lanes_i.lane[i].evt.kind)
                    KIND_WRAP: begin
                        wrap_next = wrap_next +
                                    (TIME_W - SUBTIME_W)'(pay_lanes_i.lane[i].wrap.wrap_inc);
                    end
                    KIND_TAG: begin
                        lane_valid_next[i] = 1'b1;
                        time_next[i]       = {wrap_next, pay_lanes_i.lane[i].evt.subtime};
                    end
                    default: begin
                        // Fill and kind 3 carry nothing
                        lane_valid_next[i] = 1'b0;
                    end
                endcase
            end
        end
    end

    // Wrap count and output valid
    always_ff @(posedge sys_clk) begin
        if (sys_clk_rst) begin
            wrap_cnt_q <= '0;
            m_valid_q  <= 1'b0;
        end else begin
            if (accept) begin
                wrap_cnt_q <= wrap_next;
            end
            if (accept && has_tag) begin
                m_valid_q <= 1'b1;
            end else if (m_ready_i) begin
                m_valid_q <= 1'b0;
            end
        end
    end

    // Output payload
    always_ff @(posedge sys_clk) begin
        if (accept && has_tag) begin
            m_lane_valid_q <= lane_valid_next;
            m_time_q       <= time_next;
            m_channel_q    <= chan_next;
        end
    end

    assign m_valid_o      = m_valid_q;
    assign m_lane_valid_o = m_lane_valid_q;
    assign m_time_o       = m_time_q;
    assign m_channel_o    = m_channel_q;

endmodule

// ==== verilog/tag_link_top.sv ====
// Time-tag frame receiver top level
// Input beats must already be synchronized to sys_clk and checked
// Two registered stages between s_ and m_ streams
module tag_link_top (
    input  logic                            sys_clk,
    input  logic                            sys_clk_rst,
    input  logic                            s_valid_i,
    input  link_pkg::beat_u                 s_data_i,
    input  link_pkg::lane_mask_t            s_keep_i,
    input  logic                            s_last_i,
    output logic                            s_ready_o,
    output logic                            m_valid_o,
    output link_pkg::lane_mask_t            m_lane_valid_o,
    output link_pkg::time_vec_t             m_time_o,
    output link_pkg::chan_vec_t             m_channel_o,
    input  logic                            m_ready_i,
    input  logic                            rd_en_i,
    input  logic [meas_pkg::REG_ADDR_W-1:0] rd_addr_i,
    output logic [31:0]                     rd_data_o,
    output logic                            rd_valid_o
);
    import link_pkg::*;

    // Parser to converter
    logic        pay_valid;
    beat_u       pay_lanes;
    lane_mask_t  pay_keep;
    logic        pay_first;
    logic [31:0] pay_wrap_base;
    logic        pay_ready;

    // Frame statistics pulses
    logic frame_ok_pulse;
    logic frame_drop_pulse;

    frame_parser u_parser (
        .sys_clk        (sys_clk),
        .sys_clk_rst    (sys_clk_rst),
        .s_valid_i      (s_valid_i),
        .s_data_i       (s_data_i),
        .s_keep_i       (s_keep_i),
        .s_last_i       (s_last_i),
        .s_ready_o      (s_ready_o),
        .pay_valid_o    (pay_valid),
        .pay_lanes_o    (pay_lanes),
        .pay_keep_o     (pay_keep),
        .pay_first_o    (pay_first),
        .pay_wrap_base_o(pay_wrap_base),
        .pay_ready_i    (pay_ready),
        .frame_ok_o     (frame_ok_pulse),
        .frame_drop_o   (frame_drop_pulse)
    );

    tag_converter u_converter (
        .sys_clk        (sys_clk),
        .sys_clk_rst    (sys_clk_rst),
        .pay_valid_i    (pay_valid),
        .pay_lanes_i    (pay_lanes),
        .pay_keep_i     (pay_keep),
        .pay_first_i    (pay_first),
        .pay_wrap_base_i(pay_wrap_base),
        .pay_ready_o    (pay_ready),
        .m_valid_o      (m_valid_o),
        .m_lane_valid_o (m_lane_valid_o),
        .m_time_o       (m_time_o),
        .m_channel_o    (m_channel_o),
        .m_ready_i      (m_ready_i)
    );

    // Watches the output stream, counts on each transfer
    count_rate_regs u_count_rate (
        .sys_clk       (sys_clk),
        .sys_clk_rst   (sys_clk_rst),
        .m_valid_i     (m_valid_o),
        .m_ready_i     (m_ready_i),
        .m_lane_valid_i(m_lane_valid_o),
        .m_channel_i   (m_channel_o),
        .frame_ok_i    (frame_ok_pulse),
        .frame_drop_i  (frame_drop_pulse),
        .rd_en_i       (rd_en_i),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .rd_valid_o    (rd_valid_o)
    );

endmodule
